// File: Makefile
# Verilator simulation of the matrix load/store front end

VERILATOR ?= verilator
TOP       ?= mlsu_tb
FILELIST  ?= mlsu_top.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/mlsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mlsu_tb
  import mlsu_pkg::*;
();

  localparam int N_ROWS     = 4;
  localparam int N_LANES    = 4;
  localparam int CLK_PERIOD = 100;
  localparam int NUM_INST   = 16;
  localparam int MAX_CYCLES = 40 * NUM_INST + 100;
  localparam int IN_ROW_W   = N_LANES * IN_ELEM_W;
  localparam int Q_ROW_W    = N_LANES * Q_ELEM_W;
  localparam int ACC_ROW_W  = N_LANES * ACC_ELEM_W;

  logic                 clk;
  logic                 rstnn;
  logic                 inst_ready_i;
  mlsu_inst_t           inst_data_i;
  logic                 inst_pop_o;
  logic                 op_finish_o;
  logic                 mi_sinst_wvalid_o;
  lsu_inst_t            mi_sinst_wdata_o;
  logic                 mi_sinst_wready_i;
  logic                 mi_sload_wvalid_i;
  logic [IN_ROW_W-1:0]  mi_sload_wdata_i;
  logic                 mi_sload_wready_o;
  logic                 mi_sstore_rvalid_i;
  logic                 mi_sstore_rready_o;
  logic [Q_ROW_W-1:0]   mi_sstore_rdata_o;
  logic                 mo_sinst_wvalid_o;
  lsu_inst_t            mo_sinst_wdata_o;
  logic                 mo_sinst_wready_i;
  logic                 mo_sload_wvalid_i;
  logic [ACC_ROW_W-1:0] mo_sload_wdata_i;
  logic                 mo_sload_wready_o;
  logic                 mo_sstore_rvalid_i;
  logic                 mo_sstore_rready_o;
  logic [ACC_ROW_W-1:0] mo_sstore_rdata_o;

  int          n_checks    = 0;
  int          n_errors    = 0;
  int          cycle_count = 0;
  logic [15:0] lfsr_state  = 16'd78;

  mlsu_top #(.ROWS(N_ROWS), .LANES(N_LANES)) mlsu_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks: %0d  errors: %0d", n_checks, n_errors + 1);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // --------------------
  // Checks and stimulus helpers
  // --------------------
  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_failure(input string what);
    n_errors++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_step()};
    end
    return v;
  endfunction

  // Half full range, half small values near zero
  function automatic logic [15:0] rand_elem();
    logic [15:0] v;
    if (lfsr_step()) begin
      v = rand_bits(16);
    end else begin
      v = rand_bits(10);
      v = {{6{v[9]}}, v[9:0]};
    end
    return v;
  endfunction

  // Both saturation ends and a rounding tie
  function automatic logic [15:0] edge_value(input int lane);
    case (lane)
      0:       return 16'h7fff;
      1:       return 16'h8000;
      2:       return 16'h000c;
      default: return 16'hfff4;
    endcase
  endfunction

  function automatic logic lsu_strobe(input bit stall);
    return stall ? lfsr_step() : 1'b1;
  endfunction

  // Divide by 2^s, ties away from zero, clamp to int8
  function automatic q_elem_t quant_ref(input in_elem_t x, input shift_t s);
    int v;
    int d;
    int q;
    int r;
    v = x;
    d = 1 << s;
    q = v / d;
    r = v % d;
    if (2 * ((r < 0) ? -r : r) >= d) q = (v < 0) ? q - 1 : q + 1;
    if (q > 127) q = 127;
    else if (q < -128) q = -128;
    return q[7:0];
  endfunction

  function automatic acc_elem_t dequant_ref(input acc_elem_t x, input shift_t s);
    int w;
    w = x;
    w = w * (1 << s);
    if (w > 32767) w = 32767;
    else if (w < -32768) w = -32768;
    return w[15:0];
  endfunction

  // --------------------
  // FIFO and LSU models for one instruction
  // --------------------
  task automatic run_inst(input shift_t qsh, input shift_t dqsh, input bit stall);
    logic [IN_ROW_W-1:0]  in_rows [N_ROWS];
    logic [ACC_ROW_W-1:0] acc_rows [N_ROWS];
    logic [Q_ROW_W-1:0]   q_exp [N_ROWS];
    logic [ACC_ROW_W-1:0] dq_exp [N_ROWS];
    addr_t                in_addr;
    addr_t                out_addr;
    in_elem_t             x;
    acc_elem_t            y;
    int                   mi_inst;
    int                   mo_inst;
    int                   mi_acc;
    int                   mo_acc;
    int                   mi_st;
    int                   mo_st;
    bit                   popped;
    in_addr  = rand_bits(16);
    out_addr = rand_bits(16);
    for (int r = 0; r < N_ROWS; r++) begin
      for (int l = 0; l < N_LANES; l++) begin
        x = (r == 0) ? edge_value(l) : rand_elem();
        y = (r == 0) ? edge_value(l) : rand_elem();
        in_rows[r][l*IN_ELEM_W +: IN_ELEM_W]    = x;
        acc_rows[r][l*ACC_ELEM_W +: ACC_ELEM_W] = y;
        q_exp[r][l*Q_ELEM_W +: Q_ELEM_W]        = quant_ref(x, qsh);
        dq_exp[r][l*ACC_ELEM_W +: ACC_ELEM_W]   = dequant_ref(y, dqsh);
      end
    end
    mi_inst = 0;
    mo_inst = 0;
    mi_acc  = 0;
    mo_acc  = 0;
    mi_st   = 0;
    mo_st   = 0;
    popped  = 1'b0;
    while (!popped) begin
      @(negedge clk);
      inst_ready_i       = 1'b1;
      inst_data_i        = {dqsh, qsh, out_addr, in_addr};
      mi_sinst_wready_i  = lsu_strobe(stall);
      mo_sinst_wready_i  = lsu_strobe(stall);
      // Rows keep coming past the matrix size to catch an extra accept
      mi_sload_wvalid_i  = (mi_inst > 0) && lsu_strobe(stall);
      mi_sload_wdata_i   = (mi_acc < N_ROWS) ? in_rows[mi_acc] : '1;
      mo_sload_wvalid_i  = (mo_inst > 0) && lsu_strobe(stall);
      mo_sload_wdata_i   = (mo_acc < N_ROWS) ? acc_rows[mo_acc] : '1;
      mi_sstore_rvalid_i = (mi_inst > 0) && lsu_strobe(stall);
      mo_sstore_rvalid_i = (mo_inst > 0) && lsu_strobe(stall);
      #(CLK_PERIOD / 4);
      if (mi_sinst_wvalid_o && mi_sinst_wready_i) begin
        mi_inst++;
        compare_value("mi_sinst_wdata_o", mi_sinst_wdata_o, {in_addr, OPC_READ});
      end
      if (mo_sinst_wvalid_o && mo_sinst_wready_i) begin
        mo_inst++;
        compare_value("mo_sinst_wdata_o", mo_sinst_wdata_o, {out_addr, OPC_WRITE});
      end
      // A path moving rows is not idle
      if ((mi_sload_wvalid_i && mi_sload_wready_o) ||
          (mo_sload_wvalid_i && mo_sload_wready_o) ||
          (mi_sstore_rvalid_i && mi_sstore_rready_o) ||
          (mo_sstore_rvalid_i && mo_sstore_rready_o)) begin
        compare_value("op_finish_o", op_finish_o, 0);
      end
      if (mi_sload_wvalid_i && mi_sload_wready_o) begin
        if (mi_acc >= N_ROWS) report_failure("input path accepted a row past the matrix");
        mi_acc++;
      end
      if (mo_sload_wvalid_i && mo_sload_wready_o) begin
        if (mo_acc >= N_ROWS) report_failure("output path accepted a row past the matrix");
        mo_acc++;
      end
      if (mi_sstore_rvalid_i && mi_sstore_rready_o) begin
        if (mi_st < N_ROWS) compare_value("mi_sstore_rdata_o", mi_sstore_rdata_o, q_exp[mi_st]);
        else report_failure("input store stream delivered a row past the matrix");
        mi_st++;
      end
      if (mo_sstore_rvalid_i && mo_sstore_rready_o) begin
        if (mo_st < N_ROWS) compare_value("mo_sstore_rdata_o", mo_sstore_rdata_o, dq_exp[mo_st]);
        else report_failure("output store stream delivered a row past the matrix");
        mo_st++;
      end
      if (inst_pop_o) begin
        compare_value("mi store rows at inst_pop_o", mi_st, N_ROWS);
        compare_value("mo store rows at inst_pop_o", mo_st, N_ROWS);
        compare_value("op_finish_o", op_finish_o, 1);
        popped = 1'b1;
      end
    end
    compare_value("mi_sinst transfers", mi_inst, 1);
    compare_value("mo_sinst transfers", mo_inst, 1);
    compare_value("mi_sload rows accepted", mi_acc, N_ROWS);
    compare_value("mo_sload rows accepted", mo_acc, N_ROWS);
  endtask

  // Empty FIFO and quiet LSUs
  task automatic release_fifo();
    @(negedge clk);
    inst_ready_i       = 1'b0;
    mi_sinst_wready_i  = 1'b0;
    mo_sinst_wready_i  = 1'b0;
    mi_sload_wvalid_i  = 1'b0;
    mo_sload_wvalid_i  = 1'b0;
    mi_sstore_rvalid_i = 1'b0;
    mo_sstore_rvalid_i = 1'b0;
    #(CLK_PERIOD / 4);
    compare_value("inst_pop_o", inst_pop_o, 0);
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic reset_values();
    @(negedge clk);
    #(CLK_PERIOD / 4);
    compare_value("mi_sinst_wvalid_o", mi_sinst_wvalid_o, 0);
    compare_value("mo_sinst_wvalid_o", mo_sinst_wvalid_o, 0);
    compare_value("mi_sload_wready_o", mi_sload_wready_o, 0);
    compare_value("mo_sload_wready_o", mo_sload_wready_o, 0);
    compare_value("mi_sstore_rready_o", mi_sstore_rready_o, 0);
    compare_value("mo_sstore_rready_o", mo_sstore_rready_o, 0);
    compare_value("inst_pop_o", inst_pop_o, 0);
    compare_value("op_finish_o", op_finish_o, 1);
  endtask

  task automatic single_instruction();
    run_inst(3'd3, 3'd2, 1'b0);
    release_fifo();
  endtask

  task automatic shift_sweep();
    for (int s = 0; s < 8; s++) begin
      run_inst(shift_t'(s), shift_t'(7 - s), 1'b0);
    end
    release_fifo();
  endtask

  task automatic backpressure_run();
    for (int i = 0; i < 4; i++) begin
      run_inst(shift_t'(2 * i + 1), shift_t'(i), 1'b1);
    end
    release_fifo();
  endtask

  task automatic back_to_back();
    for (int i = 0; i < 3; i++) begin
      run_inst(shift_t'(i + 1), shift_t'(i + 4), 1'b0);
    end
    release_fifo();
    repeat (6) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      compare_value("inst_pop_o", inst_pop_o, 0);
      compare_value("op_finish_o", op_finish_o, 1);
    end
  endtask

  initial begin
    rstnn              = 1'b0;
    inst_ready_i       = 1'b0;
    inst_data_i        = '0;
    mi_sinst_wready_i  = 1'b0;
    mi_sload_wvalid_i  = 1'b0;
    mi_sload_wdata_i   = '0;
    mi_sstore_rvalid_i = 1'b0;
    mo_sinst_wready_i  = 1'b0;
    mo_sload_wvalid_i  = 1'b0;
    mo_sload_wdata_i   = '0;
    mo_sstore_rvalid_i = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstnn = 1'b1;
    reset_values();
    single_instruction();
    shift_sweep();
    backpressure_run();
    back_to_back();
    $display("Checks: %0d  errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/mlsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mlsu_ctrl
  import mlsu_pkg::*;
#(
  parameter int ROWS = mlsu_pkg::ROWS
) (
  input  wire             clk,
  input  wire             rstnn,
  input  wire             inst_ready_i,
  input  wire mlsu_inst_t inst_data_i,
  input  wire             mi_sinst_wready_i,
  input  wire             mo_sinst_wready_i,
  input  wire             mi_sload_wvalid_i,
  input  wire             mo_sload_wvalid_i,
  input  wire             qa_full_i,
  input  wire             out_full_i,
  input  wire             qa_busy_i,
  input  wire             out_busy_i,
  output logic            inst_pop_o,
  output logic            op_finish_o,
  output logic            mi_sinst_wvalid_o,
  output lsu_inst_t       mi_sinst_wdata_o,
  output logic            mo_sinst_wvalid_o,
  output lsu_inst_t       mo_sinst_wdata_o,
  output logic            mi_sload_wready_o,
  output logic            mo_sload_wready_o,
  output logic            q_valid_o,
  output logic            dq_valid_o,
  output logic            qa_store_req_o,
  output logic            out_store_req_o,
  output shift_t          q_shift_o,
  output shift_t          dq_shift_o
);

  localparam int CNT_W = $clog2(ROWS + 1);

  path_state_t      q_state;
  path_state_t      dq_state;
  logic             q_served;
  logic             dq_served;
  logic [CNT_W-1:0] q_rows;
  logic [CNT_W-1:0] dq_rows;

  // Shared by both paths
  function automatic path_state_t path_next(path_state_t st, logic issue, logic full,
                                            logic busy);
    path_state_t nxt;
    nxt = st;
    case (st)
      ST_IDLE:  if (issue) nxt = ST_LOAD;
      ST_LOAD:  nxt = ST_EXEC;
      ST_EXEC:  if (full) nxt = ST_STORE;
      ST_STORE: if (!busy) nxt = ST_IDLE;
      default:  nxt = ST_IDLE;
    endcase
    return nxt;
  endfunction

  // --------------------
  // Instruction issue and pop
  // --------------------
  assign mi_sinst_wvalid_o = (q_state == ST_IDLE) & inst_ready_i & mi_sinst_wready_i & ~q_served;
  assign mo_sinst_wvalid_o = (dq_state == ST_IDLE) & inst_ready_i & mo_sinst_wready_i & ~dq_served;

  assign mi_sinst_wdata_o = {inst_data_i[INST_IN_ADDR_LSB +: ADDR_W], OPC_READ};
  assign mo_sinst_wdata_o = {inst_data_i[INST_OUT_ADDR_LSB +: ADDR_W], OPC_WRITE};
  assign q_shift_o        = inst_data_i[INST_QSH_LSB +: SHIFT_W];
  assign dq_shift_o       = inst_data_i[INST_DQSH_LSB +: SHIFT_W];

  assign op_finish_o = (q_state == ST_IDLE) & (dq_state == ST_IDLE);
  // Both paths served and back in idle
  assign inst_pop_o  = op_finish_o & q_served & dq_served;

  // --------------------
  // Load side and store requests
  // --------------------
  assign mi_sload_wready_o = (q_state == ST_EXEC) & (q_rows < CNT_W'(ROWS));
  assign mo_sload_wready_o = (dq_state == ST_EXEC) & (dq_rows < CNT_W'(ROWS));
  assign q_valid_o         = mi_sload_wvalid_i & mi_sload_wready_o;
  assign dq_valid_o        = mo_sload_wvalid_i & mo_sload_wready_o;

  assign qa_store_req_o  = (q_state == ST_EXEC) & qa_full_i;
  assign out_store_req_o = (dq_state == ST_EXEC) & out_full_i;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      q_state   <= ST_IDLE;
      dq_state  <= ST_IDLE;
      q_served  <= 1'b0;
      dq_served <= 1'b0;
      q_rows    <= '0;
      dq_rows   <= '0;
    end else begin
      q_state  <= path_next(q_state, mi_sinst_wvalid_o, qa_full_i, qa_busy_i);
      dq_state <= path_next(dq_state, mo_sinst_wvalid_o, out_full_i, out_busy_i);

      if (inst_pop_o) begin
        q_served  <= 1'b0;
        dq_served <= 1'b0;
      end else begin
        if (mi_sinst_wvalid_o) q_served <= 1'b1;
        if (mo_sinst_wvalid_o) dq_served <= 1'b1;
      end

      if (q_state == ST_LOAD) q_rows <= '0;
      else if (q_valid_o) q_rows <= q_rows + 1'b1;

      if (dq_state == ST_LOAD) dq_rows <= '0;
      else if (dq_valid_o) dq_rows <= dq_rows + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/mlsu_pkg.sv
`default_nettype none

package mlsu_pkg;

  // --------------------
  // Matrix geometry defaults
  // --------------------
  parameter int LANES = 4;
  parameter int ROWS  = 4;

  // Element and field widths
  localparam int IN_ELEM_W  = 16;
  localparam int Q_ELEM_W   = 8;
  localparam int ACC_ELEM_W = 16;
  localparam int SHIFT_W    = 3;
  localparam int ADDR_W     = 16;
  localparam int OPC_W      = 1;
  localparam int LSU_INST_W = ADDR_W + OPC_W;
  localparam int INST_W     = 2 * ADDR_W + 2 * SHIFT_W;

  typedef logic signed [IN_ELEM_W-1:0]  in_elem_t;
  typedef logic signed [Q_ELEM_W-1:0]   q_elem_t;
  typedef logic signed [ACC_ELEM_W-1:0] acc_elem_t;
  typedef logic        [SHIFT_W-1:0]    shift_t;
  typedef logic        [ADDR_W-1:0]     addr_t;
  typedef logic        [LSU_INST_W-1:0] lsu_inst_t;
  typedef logic        [INST_W-1:0]     mlsu_inst_t;

  // LSU opcodes in the low bit of lsu_inst_t
  localparam logic [OPC_W-1:0] OPC_READ  = 1'b0;
  localparam logic [OPC_W-1:0] OPC_WRITE = 1'b1;

  // Instruction word fields from the low end
  localparam int INST_IN_ADDR_LSB  = 0;
  localparam int INST_OUT_ADDR_LSB = INST_IN_ADDR_LSB + ADDR_W;
  localparam int INST_QSH_LSB      = INST_OUT_ADDR_LSB + ADDR_W;
  localparam int INST_DQSH_LSB     = INST_QSH_LSB + SHIFT_W;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_EXEC,
    ST_STORE
  } path_state_t;

endpackage

`default_nettype wire

// File: logic/mlsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mlsu_top
  import mlsu_pkg::*;
#(
  parameter int ROWS  = mlsu_pkg::ROWS,
  parameter int LANES = mlsu_pkg::LANES
) (
  input  wire                         clk,
  input  wire                         rstnn,
  // Instruction FIFO
  input  wire                         inst_ready_i,
  input  wire mlsu_inst_t             inst_data_i,
  output logic                        inst_pop_o,
  output logic                        op_finish_o,
  // Input LSU
  output logic                        mi_sinst_wvalid_o,
  output lsu_inst_t                   mi_sinst_wdata_o,
  input  wire                         mi_sinst_wready_i,
  input  wire                         mi_sload_wvalid_i,
  input  wire [LANES*IN_ELEM_W-1:0]   mi_sload_wdata_i,
  output logic                        mi_sload_wready_o,
  input  wire                         mi_sstore_rvalid_i,
  output logic                        mi_sstore_rready_o,
  output logic [LANES*Q_ELEM_W-1:0]   mi_sstore_rdata_o,
  // Output LSU
  output logic                        mo_sinst_wvalid_o,
  output lsu_inst_t                   mo_sinst_wdata_o,
  input  wire                         mo_sinst_wready_i,
  input  wire                         mo_sload_wvalid_i,
  input  wire [LANES*ACC_ELEM_W-1:0]  mo_sload_wdata_i,
  output logic                        mo_sload_wready_o,
  input  wire                         mo_sstore_rvalid_i,
  output logic                        mo_sstore_rready_o,
  output logic [LANES*ACC_ELEM_W-1:0] mo_sstore_rdata_o
);

  localparam int Q_ROW_W   = LANES * Q_ELEM_W;
  localparam int ACC_ROW_W = LANES * ACC_ELEM_W;

  logic                 q_valid;
  logic                 dq_valid;
  shift_t               q_shift;
  shift_t               dq_shift;
  logic                 qa_full;
  logic                 out_full;
  logic                 qa_busy;
  logic                 out_busy;
  logic                 qa_store_req;
  logic                 out_store_req;
  logic                 qa_wen;
  logic                 out_wen;
  logic [Q_ROW_W-1:0]   qa_wdata;
  logic [ACC_ROW_W-1:0] out_wdata;
  logic                 qa_ren;
  logic                 out_ren;
  logic [Q_ROW_W-1:0]   qa_rdata;
  logic [ACC_ROW_W-1:0] out_rdata;

  mlsu_ctrl #(.ROWS(ROWS)) u_ctrl (
    .clk(clk), .rstnn(rstnn),
    .inst_ready_i(inst_ready_i), .inst_data_i(inst_data_i),
    .mi_sinst_wready_i(mi_sinst_wready_i), .mo_sinst_wready_i(mo_sinst_wready_i),
    .mi_sload_wvalid_i(mi_sload_wvalid_i), .mo_sload_wvalid_i(mo_sload_wvalid_i),
    .qa_full_i(qa_full), .out_full_i(out_full),
    .qa_busy_i(qa_busy), .out_busy_i(out_busy),
    .inst_pop_o(inst_pop_o), .op_finish_o(op_finish_o),
    .mi_sinst_wvalid_o(mi_sinst_wvalid_o), .mi_sinst_wdata_o(mi_sinst_wdata_o),
    .mo_sinst_wvalid_o(mo_sinst_wvalid_o), .mo_sinst_wdata_o(mo_sinst_wdata_o),
    .mi_sload_wready_o(mi_sload_wready_o), .mo_sload_wready_o(mo_sload_wready_o),
    .q_valid_o(q_valid), .dq_valid_o(dq_valid),
    .qa_store_req_o(qa_store_req), .out_store_req_o(out_store_req),
    .q_shift_o(q_shift), .dq_shift_o(dq_shift)
  );

  // --------------------
  // Quantize path
  // --------------------
  row_quantizer #(.LANES(LANES)) u_quant (
    .clk(clk), .rstnn(rstnn), .valid_i(q_valid), .shift_i(q_shift),
    .row_i(mi_sload_wdata_i), .valid_o(qa_wen), .row_o(qa_wdata)
  );

  row_buffer #(.ROWS(ROWS), .ROW_W(Q_ROW_W)) u_qa_buf (
    .clk(clk), .rstnn(rstnn), .wen_i(qa_wen), .wdata_i(qa_wdata),
    .ren_i(qa_ren), .rdata_o(qa_rdata), .full_o(qa_full)
  );

  row_store_seq #(.ROWS(ROWS), .ROW_W(Q_ROW_W)) u_qa_store (
    .clk(clk), .rstnn(rstnn), .req_i(qa_store_req), .rdata_i(qa_rdata),
    .sstore_rvalid_i(mi_sstore_rvalid_i), .busy_o(qa_busy), .ren_o(qa_ren),
    .sstore_rready_o(mi_sstore_rready_o), .sstore_rdata_o(mi_sstore_rdata_o)
  );

  // --------------------
  // Dequantize path
  // --------------------
  row_dequantizer #(.LANES(LANES)) u_dequant (
    .clk(clk), .rstnn(rstnn), .valid_i(dq_valid), .shift_i(dq_shift),
    .row_i(mo_sload_wdata_i), .valid_o(out_wen), .row_o(out_wdata)
  );

  row_buffer #(.ROWS(ROWS), .ROW_W(ACC_ROW_W)) u_out_buf (
    .clk(clk), .rstnn(rstnn), .wen_i(out_wen), .wdata_i(out_wdata),
    .ren_i(out_ren), .rdata_o(out_rdata), .full_o(out_full)
  );

  row_store_seq #(.ROWS(ROWS), .ROW_W(ACC_ROW_W)) u_out_store (
    .clk(clk), .rstnn(rstnn), .req_i(out_store_req), .rdata_i(out_rdata),
    .sstore_rvalid_i(mo_sstore_rvalid_i), .busy_o(out_busy), .ren_o(out_ren),
    .sstore_rready_o(mo_sstore_rready_o), .sstore_rdata_o(mo_sstore_rdata_o)
  );

endmodule

`default_nettype wire

// File: logic/row_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module row_buffer
  import mlsu_pkg::*;
#(
  parameter int ROWS  = mlsu_pkg::ROWS,
  parameter int ROW_W = mlsu_pkg::LANES * Q_ELEM_W
) (
  input  wire              clk,
  input  wire              rstnn,
  input  wire              wen_i,
  input  wire [ROW_W-1:0]  wdata_i,
  input  wire              ren_i,
  output logic [ROW_W-1:0] rdata_o,
  output logic             full_o
);

  localparam int PTR_W = (ROWS > 1) ? $clog2(ROWS) : 1;
  localparam int CNT_W = $clog2(ROWS + 1);

  logic [ROW_W-1:0] mem [ROWS];
  logic [PTR_W-1:0] wptr;
  logic [PTR_W-1:0] rptr;
  logic [CNT_W-1:0] count;
  logic             wr;
  logic             rd;

  assign full_o  = (count == CNT_W'(ROWS));
  assign wr      = wen_i & ~full_o;
  assign rd      = ren_i & (count != '0);
  assign rdata_o = mem[rptr];

  always_ff @(posedge clk) begin
    if (wr) mem[wptr] <= wdata_i;
  end

  // Pointers wrap at ROWS so an emptied buffer starts over at row 0
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (wr) wptr <= (wptr == PTR_W'(ROWS - 1)) ? '0 : wptr + 1'b1;
      if (rd) rptr <= (rptr == PTR_W'(ROWS - 1)) ? '0 : rptr + 1'b1;
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/row_dequantizer.sv
`timescale 1ns/1ps
`default_nettype none

module row_dequantizer
  import mlsu_pkg::*;
#(
  parameter int LANES = mlsu_pkg::LANES
) (
  input  wire                         clk,
  input  wire                         rstnn,
  input  wire                         valid_i,
  input  wire shift_t                 shift_i,
  input  wire [LANES*ACC_ELEM_W-1:0]  row_i,
  output logic                        valid_o,
  output logic [LANES*ACC_ELEM_W-1:0] row_o
);

  logic [LANES*ACC_ELEM_W-1:0] dq_row;

  // Shift of up to 7 fits in 24 bits before the int16 clamp
  function automatic acc_elem_t dequant_lane(acc_elem_t x, shift_t s);
    logic signed [23:0] w;
    w = 24'(x) <<< s;
    if (w > 24'sd32767) return 16'sh7fff;
    else if (w < -24'sd32768) return 16'sh8000;
    else return w[15:0];
  endfunction

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      dq_row[i*ACC_ELEM_W +: ACC_ELEM_W] =
        dequant_lane(row_i[i*ACC_ELEM_W +: ACC_ELEM_W], shift_i);
    end
  end

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) valid_o <= 1'b0;
    else valid_o <= valid_i;
  end

  always_ff @(posedge clk) begin
    if (valid_i) row_o <= dq_row;
  end

endmodule

`default_nettype wire

// File: logic/row_quantizer.sv
`timescale 1ns/1ps
`default_nettype none

module row_quantizer
  import mlsu_pkg::*;
#(
  parameter int LANES = mlsu_pkg::LANES
) (
  input  wire                          clk,
  input  wire                          rstnn,
  input  wire                          valid_i,
  input  wire shift_t                  shift_i,
  input  wire [LANES*IN_ELEM_W-1:0]    row_i,
  output logic                         valid_o,
  output logic [LANES*Q_ELEM_W-1:0]    row_o
);

  logic [LANES*Q_ELEM_W-1:0] q_row;

  // Round half away from zero, then clamp to int8
  function automatic q_elem_t quant_lane(in_elem_t x, shift_t s);
    logic signed [17:0] xe;
    logic signed [17:0] mag;
    logic signed [17:0] half;
    logic signed [17:0] rnd;
    logic signed [17:0] res;
    xe   = 18'(x);
    mag  = xe[17] ? -xe : xe;
    half = (s == '0) ? 18'sd0 : (18'sd1 <<< (s - 3'd1));
    rnd  = (mag + half) >>> s;
    res  = xe[17] ? -rnd : rnd;
    if (res > 18'sd127) return 8'sd127;
    else if (res < -18'sd128) return -8'sd128;
    else return res[7:0];
  endfunction

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      q_row[i*Q_ELEM_W +: Q_ELEM_W] = quant_lane(row_i[i*IN_ELEM_W +: IN_ELEM_W], shift_i);
    end
  end

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) valid_o <= 1'b0;
    else valid_o <= valid_i;
  end

  always_ff @(posedge clk) begin
    if (valid_i) row_o <= q_row;
  end

endmodule

`default_nettype wire

// File: logic/row_store_seq.sv
`timescale 1ns/1ps
`default_nettype none

module row_store_seq
  import mlsu_pkg::*;
#(
  parameter int ROWS  = mlsu_pkg::ROWS,
  parameter int ROW_W = mlsu_pkg::LANES * Q_ELEM_W
) (
  input  wire              clk,
  input  wire              rstnn,
  input  wire              req_i,
  input  wire [ROW_W-1:0]  rdata_i,
  input  wire              sstore_rvalid_i,
  output logic             busy_o,
  output logic             ren_o,
  output logic             sstore_rready_o,
  output logic [ROW_W-1:0] sstore_rdata_o
);

  localparam int CNT_W = $clog2(ROWS + 1);

  logic [CNT_W-1:0] sent;
  logic             last;

  // One row per LSU request while busy
  assign sstore_rready_o = busy_o & sstore_rvalid_i;
  assign sstore_rdata_o  = rdata_i;
  assign ren_o           = sstore_rready_o;
  assign last            = sstore_rready_o & (sent == CNT_W'(ROWS - 1));

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      busy_o <= 1'b0;
      sent   <= '0;
    end else if (req_i && !busy_o) begin
      busy_o <= 1'b1;
      sent   <= '0;
    end else if (last) begin
      busy_o <= 1'b0;
      sent   <= '0;
    end else if (sstore_rready_o) begin
      sent <= sent + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: mlsu_top.f
logic/mlsu_pkg.sv
logic/mlsu_ctrl.sv
logic/row_quantizer.sv
logic/row_dequantizer.sv
logic/row_buffer.sv
logic/row_store_seq.sv
logic/mlsu_top.sv
bench/mlsu_tb.sv
